//--- include/cdc_fifo_defs.svh
`ifndef CDC_FIFO_DEFS_SVH
`define CDC_FIFO_DEFS_SVH

// Payload bits carried by one beat, not counting the last flag.
`define CDC_DATA_W 8

// Number of entries in the storage array.
// This must stay a power of two so the Gray pointers wrap cleanly.
`define CDC_FIFO_DEPTH 16

// Almost-full is raised once at least this many entries are in use.
`define CDC_AFULL_LVL 12

// Almost-empty is raised while at most this many entries are in use.
`define CDC_AEMPTY_LVL 2

`endif

//--- source/cdc_fifo_pkg.sv
`default_nettype none

`include "cdc_fifo_defs.svh"

package cdc_fifo_pkg;

  // One packet beat as it travels through the FIFO.
  typedef struct packed {
    logic                   last;
    logic [`CDC_DATA_W-1:0] data;
  } pkt_beat_t;

  // Status seen by the producer in the write clock domain.
  typedef struct packed {
    logic full;
    logic afull;
  } wr_flags_t;

  // Status seen by the consumer in the read clock domain.
  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_flags_t;

endpackage

`default_nettype wire

//--- source/dual_port_ram.sv
`timescale 1ns/100ps
`default_nettype none

module dual_port_ram
  import cdc_fifo_pkg::*;
#(
  parameter type beat_t = pkt_beat_t,
  parameter int  DEPTH  = 16,
  localparam int AW     = $clog2(DEPTH)
) (
  input  wire logic          wr_clk,
  input  wire logic          wr_fire,
  input  wire logic [AW-1:0] wr_addr,
  input  wire beat_t         wr_beat,
  input  wire logic          rd_clk,
  input  wire logic          rd_rst_n,
  input  wire logic          rd_fire,
  input  wire logic [AW-1:0] rd_addr,
  output beat_t              rd_beat
);

  beat_t mem [DEPTH];

  // Write port, owned entirely by the write clock domain.
  always_ff @(posedge wr_clk) begin
    if (wr_fire) begin
      mem[wr_addr] <= wr_beat;
    end
  end

  // Registered read port. The output holds its value between reads,
  // so the consumer may sample it any time after rd_valid.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_beat <= '0;
    end else if (rd_fire) begin
      rd_beat <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- source/fifo_wr_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "cdc_fifo_defs.svh"

module fifo_wr_ctrl
  import cdc_fifo_pkg::*;
#(
  localparam int AW = $clog2(`CDC_FIFO_DEPTH)
) (
  input  wire logic        wr_clk,
  input  wire logic        wr_rst_n,
  input  wire logic        wr_en,
  input  wire logic [AW:0] rd_gray,
  output logic             wr_fire,
  output logic [AW-1:0]    wr_addr,
  output logic [AW:0]      wr_gray,
  output wr_flags_t        wr_flags
);

  localparam int PW = AW + 1;

  logic [AW:0] wr_bin;
  logic [AW:0] wr_bin_nxt;
  logic [AW:0] wr_gray_nxt;
  logic [AW:0] rd_gray_s1;
  logic [AW:0] rd_gray_s2;
  logic [AW:0] rd_bin_s;
  logic [AW:0] used_nxt;
  logic        full_nxt;
  logic        afull_nxt;

  // A write is only taken while the FIFO has room.
  assign wr_fire = wr_en & ~wr_flags.full;

  assign wr_bin_nxt  = wr_bin + {{AW{1'b0}}, wr_fire};
  assign wr_gray_nxt = (wr_bin_nxt >> 1) ^ wr_bin_nxt;
  assign wr_addr     = wr_bin[AW-1:0];

  // Two-flop synchronizer for the read pointer coming from rd_clk.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  always_comb begin
    rd_bin_s[AW] = rd_gray_s2[AW];
    for (int i = AW - 1; i >= 0; i--) begin
      rd_bin_s[i] = rd_bin_s[i+1] ^ rd_gray_s2[i];
    end
  end

  // Full means the write pointer is one lap ahead of the read pointer.
  // In Gray code that shows up as the top two bits inverted.
  assign full_nxt  = (wr_gray_nxt == {~rd_gray_s2[AW:AW-1], rd_gray_s2[AW-2:0]});
  assign used_nxt  = wr_bin_nxt - rd_bin_s;
  assign afull_nxt = (used_nxt >= PW'(`CDC_AFULL_LVL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin   <= '0;
      wr_gray  <= '0;
      wr_flags <= '0;
    end else begin
      wr_bin         <= wr_bin_nxt;
      wr_gray        <= wr_gray_nxt;
      wr_flags.full  <= full_nxt;
      wr_flags.afull <= afull_nxt;
    end
  end

endmodule

`default_nettype wire

//--- source/fifo_rd_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "cdc_fifo_defs.svh"

module fifo_rd_ctrl
  import cdc_fifo_pkg::*;
#(
  localparam int AW = $clog2(`CDC_FIFO_DEPTH)
) (
  input  wire logic        rd_clk,
  input  wire logic        rd_rst_n,
  input  wire logic        rd_en,
  input  wire logic [AW:0] wr_gray,
  output logic             rd_fire,
  output logic [AW-1:0]    rd_addr,
  output logic [AW:0]      rd_gray,
  output logic             rd_valid,
  output rd_flags_t        rd_flags
);

  localparam int PW = AW + 1;

  logic [AW:0] rd_bin;
  logic [AW:0] rd_bin_nxt;
  logic [AW:0] rd_gray_nxt;
  logic [AW:0] wr_gray_s1;
  logic [AW:0] wr_gray_s2;
  logic [AW:0] wr_bin_s;
  logic [AW:0] used_nxt;
  logic        empty_nxt;
  logic        aempty_nxt;

  // A read is only taken while there is something to read.
  assign rd_fire = rd_en & ~rd_flags.empty;

  assign rd_bin_nxt  = rd_bin + {{AW{1'b0}}, rd_fire};
  assign rd_gray_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;
  assign rd_addr     = rd_bin[AW-1:0];

  // Two-flop synchronizer for the write pointer coming from wr_clk.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  always_comb begin
    wr_bin_s[AW] = wr_gray_s2[AW];
    for (int i = AW - 1; i >= 0; i--) begin
      wr_bin_s[i] = wr_bin_s[i+1] ^ wr_gray_s2[i];
    end
  end

  // Empty when the read pointer has caught up with the write pointer.
  assign empty_nxt  = (rd_gray_nxt == wr_gray_s2);
  assign used_nxt   = wr_bin_s - rd_bin_nxt;
  assign aempty_nxt = (used_nxt <= PW'(`CDC_AEMPTY_LVL));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin          <= '0;
      rd_gray         <= '0;
      rd_valid        <= 1'b0;
      rd_flags.empty  <= 1'b1;
      rd_flags.aempty <= 1'b1;
    end else begin
      rd_bin          <= rd_bin_nxt;
      rd_gray         <= rd_gray_nxt;
      rd_valid        <= rd_fire;
      rd_flags.empty  <= empty_nxt;
      rd_flags.aempty <= aempty_nxt;
    end
  end

endmodule

`default_nettype wire

//--- source/async_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "cdc_fifo_defs.svh"

module async_fifo
  import cdc_fifo_pkg::*;
#(
  parameter type beat_t = pkt_beat_t
) (
  input  wire logic  wr_clk,
  input  wire logic  wr_rst_n,
  input  wire logic  wr_en,
  input  wire beat_t wr_beat,
  output wr_flags_t  wr_flags,
  input  wire logic  rd_clk,
  input  wire logic  rd_rst_n,
  input  wire logic  rd_en,
  output beat_t      rd_beat,
  output logic       rd_valid,
  output rd_flags_t  rd_flags
);

  localparam int AW = $clog2(`CDC_FIFO_DEPTH);

  logic          wr_fire;
  logic [AW-1:0] wr_addr;
  logic [AW:0]   wr_gray;
  logic          rd_fire;
  logic [AW-1:0] rd_addr;
  logic [AW:0]   rd_gray;

  dual_port_ram #(
    .beat_t (beat_t),
    .DEPTH  (`CDC_FIFO_DEPTH)
  ) dual_port_ram_i (
    .wr_clk   (wr_clk),
    .wr_fire  (wr_fire),
    .wr_addr  (wr_addr),
    .wr_beat  (wr_beat),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_fire  (rd_fire),
    .rd_addr  (rd_addr),
    .rd_beat  (rd_beat)
  );

  // Each controller sees only the other's Gray pointer.
  fifo_wr_ctrl fifo_wr_ctrl_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .rd_gray  (rd_gray),
    .wr_fire  (wr_fire),
    .wr_addr  (wr_addr),
    .wr_gray  (wr_gray),
    .wr_flags (wr_flags)
  );

  fifo_rd_ctrl fifo_rd_ctrl_i (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .wr_gray  (wr_gray),
    .rd_fire  (rd_fire),
    .rd_addr  (rd_addr),
    .rd_gray  (rd_gray),
    .rd_valid (rd_valid),
    .rd_flags (rd_flags)
  );

endmodule

`default_nettype wire

//--- tb/async_fifo_asserts.sv
`timescale 1ns/100ps
`default_nettype none

`include "cdc_fifo_defs.svh"

module async_fifo_asserts
  import cdc_fifo_pkg::*;
#(
  localparam int AW = $clog2(`CDC_FIFO_DEPTH)
) (
  input wire logic        wr_clk,
  input wire logic        wr_rst_n,
  input wire logic        wr_fire,
  input wire wr_flags_t   wr_flags,
  input wire logic [AW:0] wr_gray,
  input wire logic        rd_clk,
  input wire logic        rd_rst_n,
  input wire logic        rd_fire,
  input wire rd_flags_t   rd_flags,
  input wire logic [AW:0] rd_gray,
  input wire logic        rd_valid
);

  wr_fire_not_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    !(wr_fire && wr_flags.full))
    else $error("wr_fire high while full is high");

  rd_fire_not_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    !(rd_fire && rd_flags.empty))
    else $error("rd_fire high while empty is high");

  // A Gray pointer crossing domains may move by one bit at most.
  wr_gray_one_bit: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1)
    else $error("wr_gray changed by more than one bit");

  rd_gray_one_bit: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1)
    else $error("rd_gray changed by more than one bit");

  rd_valid_after_fire: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_fire |=> rd_valid)
    else $error("rd_valid missing one cycle after rd_fire");

  rd_valid_only_after_fire: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    !rd_fire |=> !rd_valid)
    else $error("rd_valid high without a read one cycle earlier");

endmodule

bind async_fifo async_fifo_asserts async_fifo_asserts_i (
  .wr_clk   (wr_clk),
  .wr_rst_n (wr_rst_n),
  .wr_fire  (wr_fire),
  .wr_flags (wr_flags),
  .wr_gray  (wr_gray),
  .rd_clk   (rd_clk),
  .rd_rst_n (rd_rst_n),
  .rd_fire  (rd_fire),
  .rd_flags (rd_flags),
  .rd_gray  (rd_gray),
  .rd_valid (rd_valid)
);

`default_nettype wire

//--- tb/async_fifo_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cdc_fifo_defs.svh"

module async_fifo_tb
  import cdc_fifo_pkg::*;
;

  localparam int RD_PERIOD  = 4;
  localparam int WR_PERIOD  = 6;
  localparam int DEPTH      = `CDC_FIFO_DEPTH;
  localparam int RAND_BEATS = 300;
  // Random traffic needs about eight ns per beat and the directed tests a few
  // write cycles per entry, so this budget leaves a wide margin.
  localparam int WATCHDOG_NS = WR_PERIOD * (16 * RAND_BEATS + 64 * DEPTH) + 2000;

  logic      wr_clk;
  logic      wr_rst_n;
  logic      wr_en;
  pkt_beat_t wr_beat;
  wr_flags_t wr_flags;
  logic      rd_clk;
  logic      rd_rst_n;
  logic      rd_en;
  pkt_beat_t rd_beat;
  logic      rd_valid;
  rd_flags_t rd_flags;

  pkt_beat_t ref_q[$];
  logic      rd_pending;
  int        err_count;
  int        check_count;
  int        wr_accepts;
  int        rd_count;

  async_fifo #(
    .beat_t (pkt_beat_t)
  ) async_fifo_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_beat  (wr_beat),
    .wr_flags (wr_flags),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_beat  (rd_beat),
    .rd_valid (rd_valid),
    .rd_flags (rd_flags)
  );

  initial begin
    rd_clk = 1'b0;
    forever #(RD_PERIOD / 2) rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #(WR_PERIOD / 2) wr_clk = ~wr_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t: the tests did not finish in time", $time);
    $display("Errors found");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  function automatic pkt_beat_t random_beat();
    pkt_beat_t b;
    b.last = 1'($urandom_range(0, 1));
    b.data = `CDC_DATA_W'($urandom);
    return b;
  endfunction

  // The full flag is stable between write edges, so it tells here whether
  // the coming edge will take the beat.
  task automatic write_step(input logic en, input pkt_beat_t beat);
    @(negedge wr_clk);
    wr_en   = en;
    wr_beat = beat;
    if (en && !wr_flags.full) begin
      ref_q.push_back(beat);
      wr_accepts++;
    end
  endtask

  // Collects the result of the previous read edge, then sets up the next one.
  task automatic read_step(input logic en);
    pkt_beat_t exp_beat;
    @(negedge rd_clk);
    check_value("rd_valid", rd_pending, rd_valid);
    if (rd_valid) begin
      rd_count++;
      if (ref_q.size() == 0) begin
        err_count++;
        $display("At %0t rd_valid was high but no beat was expected", $time);
      end else begin
        exp_beat = ref_q.pop_front();
        check_value("rd_beat", exp_beat, rd_beat);
      end
    end
    rd_en      = en;
    rd_pending = en && !rd_flags.empty;
  endtask

  task automatic settle();
    repeat (5) @(negedge wr_clk);
  endtask

  task automatic check_levels();
    int used;
    used = ref_q.size();
    @(negedge rd_clk);
    check_value("rd_flags.empty", used == 0, rd_flags.empty);
    check_value("rd_flags.aempty", used <= `CDC_AEMPTY_LVL, rd_flags.aempty);
    @(negedge wr_clk);
    check_value("wr_flags.full", used == DEPTH, wr_flags.full);
    check_value("wr_flags.afull", used >= `CDC_AFULL_LVL, wr_flags.afull);
  endtask

  task automatic fill_to(input int level);
    while (ref_q.size() < level) begin
      write_step(1'b1, random_beat());
    end
    write_step(1'b0, '0);
  endtask

  task automatic drain_to(input int level);
    while (ref_q.size() > level) begin
      read_step(1'b1);
      read_step(1'b0);
    end
  endtask

  task automatic test_reset_state();
    check_levels();
    check_value("rd_valid", 1'b0, rd_valid);
  endtask

  task automatic test_fill_until_full();
    for (int k = 0; k < DEPTH; k++) begin
      write_step(1'b1, random_beat());
      write_step(1'b0, '0);
      check_value("wr_flags.afull", ref_q.size() >= `CDC_AFULL_LVL, wr_flags.afull);
      check_value("wr_flags.full", ref_q.size() == DEPTH, wr_flags.full);
    end
    // This beat must never come out of the FIFO.
    write_step(1'b1, '{last: 1'b1, data: 8'ha5});
    write_step(1'b0, '0);
    check_value("wr_flags.full", 1'b1, wr_flags.full);
    check_value("model size", DEPTH, ref_q.size());
  endtask

  task automatic test_drain_in_order();
    int rd_base;
    rd_base = rd_count;
    settle();
    repeat (DEPTH + 3) read_step(1'b1);
    read_step(1'b0);
    check_value("beats read", DEPTH, rd_count - rd_base);
    check_value("model size", 0, ref_q.size());
    check_value("rd_flags.empty", 1'b1, rd_flags.empty);
  endtask

  task automatic test_threshold_levels();
    int up_levels[6] = '{1, 2, 3, 8, 12, 16};
    int down_levels[5] = '{13, 11, 2, 1, 0};
    settle();
    check_levels();
    foreach (up_levels[i]) begin
      fill_to(up_levels[i]);
      settle();
      check_levels();
    end
    foreach (down_levels[i]) begin
      drain_to(down_levels[i]);
      settle();
      check_levels();
    end
  endtask

  task automatic random_writer(input int wr_base);
    logic en;
    while (wr_accepts - wr_base < RAND_BEATS) begin
      en = ($urandom_range(0, 3) != 0);
      write_step(en, random_beat());
    end
    write_step(1'b0, '0);
  endtask

  task automatic random_reader(input int rd_base);
    logic en;
    while (rd_count - rd_base < RAND_BEATS) begin
      en = 1'($urandom_range(0, 1));
      read_step(en);
    end
    read_step(1'b0);
  endtask

  task automatic test_random_traffic();
    int wr_base;
    int rd_base;
    wr_base = wr_accepts;
    rd_base = rd_count;
    fork
      random_writer(wr_base);
      random_reader(rd_base);
    join
    check_value("beats read", RAND_BEATS, rd_count - rd_base);
    settle();
    check_levels();
  endtask

  initial begin
    wr_rst_n    = 1'b0;
    rd_rst_n    = 1'b0;
    wr_en       = 1'b0;
    wr_beat     = '0;
    rd_en       = 1'b0;
    rd_pending  = 1'b0;
    err_count   = 0;
    check_count = 0;
    wr_accepts  = 0;
    rd_count    = 0;
    void'($urandom(32'hce823fe3));

    repeat (8) @(posedge rd_clk);
    @(negedge rd_clk);
    rd_rst_n = 1'b1;
    @(negedge wr_clk);
    wr_rst_n = 1'b1;

    test_reset_state();
    test_fill_until_full();
    test_drain_in_order();
    test_threshold_levels();
    test_random_traffic();

    $display("Error count: %0d, checks run: %0d", err_count, check_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
source/cdc_fifo_pkg.sv
source/dual_port_ram.sv
source/fifo_wr_ctrl.sv
source/fifo_rd_ctrl.sv
source/async_fifo.sv
tb/async_fifo_asserts.sv
tb/async_fifo_tb.sv

//--- Bender.yml
package:
  name: async_fifo

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/cdc_fifo_pkg.sv
      - source/dual_port_ram.sv
      - source/fifo_wr_ctrl.sv
      - source/fifo_rd_ctrl.sv
      - source/async_fifo.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/async_fifo_asserts.sv
      - tb/async_fifo_tb.sv
